// File: hw/wb_pkg.sv
`default_nettype none

package wb_pkg;

	// byte address of an evicted line
	localparam int ADDR_W = 32;

	// a line is a single beat on the W channel
	localparam int DATA_W = 64;

	// line offset bits, zeroed before the address goes out on AW
	localparam int OFFSET_W = 3;

	// AXI ID carries the bank number, so at most 2**ID_W banks
	localparam int ID_W = 4;

	// one FIFO entry holds address and data side by side
	localparam int LINE_W = ADDR_W + DATA_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ID_W-1:0] axi_id_t;

	// per-bank queue state
	typedef enum logic {
		WBQ_IDLE,	// nothing staged, waiting for the FIFO
		WBQ_READY	// line staged, AW/W request raised
	} wbq_state_t;

endpackage

`default_nettype wire

// File: hw/wb_fifo.sv
`default_nettype none

module wb_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push_i,
	input  logic [WIDTH-1:0] push_data_i,
	output logic             afull_o,
	output logic             empty_o,
	input  logic             pop_i,
	output logic [WIDTH-1:0] head_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wptr_q;
	logic [PTR_W-1:0] rptr_q;
	logic [CNT_W-1:0] count_q;
	logic             do_push;
	logic             do_pop;

	// a push into a full buffer is dropped, the source is held off by afull
	assign do_push = push_i && (count_q != CNT_W'(DEPTH));
	assign do_pop  = pop_i && (count_q != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr_q  <= '0;
			rptr_q  <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
			end
			if (do_pop) begin
				rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wptr_q] <= push_data_i;
		end
	end

	assign head_o  = mem[rptr_q];	// first word is visible before the pop
	assign empty_o = (count_q == '0);

	// one slot of slack left so a strobe already on its way still fits
	assign afull_o = (count_q >= CNT_W'(DEPTH - 1));

endmodule

`default_nettype wire

// File: hw/wb_queue.sv
`default_nettype none

module wb_queue #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic          clk,
	input  logic          rst_n,

	input  logic          push_i,
	input  wb_pkg::addr_t push_addr_i,
	input  wb_pkg::data_t push_data_i,
	output logic          afull_o,

	output logic          req_o,
	output wb_pkg::addr_t addr_o,
	output wb_pkg::data_t data_o,
	input  logic          gnt_ready_i
);

	wb_pkg::wbq_state_t state_q;
	wb_pkg::wbq_state_t state_d;

	logic [wb_pkg::LINE_W-1:0] fifo_head;
	logic                      fifo_empty;
	logic                      fifo_pop;
	logic                      load;
	wb_pkg::addr_t             head_addr;
	wb_pkg::addr_t             addr_q;
	wb_pkg::data_t             data_q;

	wb_fifo #(
		.DEPTH (FIFO_DEPTH),
		.WIDTH (wb_pkg::LINE_W)
	) u_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push_i      (push_i),
		.push_data_i ({push_addr_i, push_data_i}),
		.afull_o     (afull_o),
		.empty_o     (fifo_empty),
		.pop_i       (fifo_pop),
		.head_o      (fifo_head)
	);

	assign head_addr = fifo_head[wb_pkg::DATA_W +: wb_pkg::ADDR_W];

	always_comb begin
		state_d  = state_q;
		load     = 1'b0;
		fifo_pop = 1'b0;
		case (state_q)
			wb_pkg::WBQ_IDLE: begin
				if (!fifo_empty) begin
					load    = 1'b1;
					state_d = wb_pkg::WBQ_READY;
				end
			end
			wb_pkg::WBQ_READY: begin
				// the entry stays in the FIFO until the handshake, so afull counts it
				if (gnt_ready_i) begin
					fifo_pop = 1'b1;
					state_d  = wb_pkg::WBQ_IDLE;
				end
			end
			default: state_d = wb_pkg::WBQ_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= wb_pkg::WBQ_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			addr_q <= {head_addr[wb_pkg::ADDR_W-1:wb_pkg::OFFSET_W],
				{wb_pkg::OFFSET_W{1'b0}}};	// line aligned
			data_q <= fifo_head[wb_pkg::DATA_W-1:0];
		end
	end

	assign req_o  = (state_q == wb_pkg::WBQ_READY);	// AW and W valid together
	assign addr_o = addr_q;
	assign data_o = data_q;

endmodule

`default_nettype wire

// File: hw/evict_router.sv
`default_nettype none

module evict_router #(
	parameter int NUM_BANKS = 4
) (
	input  logic                 evict_i,
	input  wb_pkg::addr_t        evict_addr_i,
	input  logic [NUM_BANKS-1:0] bank_afull_i,
	output logic [NUM_BANKS-1:0] push_o,
	output logic                 evict_afull_o
);

	localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

	logic [BANK_W-1:0] bank_sel;

	// bank index sits just above the line offset
	generate
		if (NUM_BANKS > 1) begin : g_decode
			assign bank_sel = evict_addr_i[wb_pkg::OFFSET_W +: BANK_W];
		end else begin : g_single
			assign bank_sel = '0;
		end
	endgenerate

	always_comb begin
		push_o = '0;
		for (int k = 0; k < NUM_BANKS; k++) begin
			if (evict_i && (bank_sel == BANK_W'(k))) begin
				push_o[k] = 1'b1;
			end
		end
	end

	// the source sees one level for all banks, since it cannot tell where the next line goes
	assign evict_afull_o = |bank_afull_i;

endmodule

`default_nettype wire

// File: hw/axi_wr_arbiter.sv
`default_nettype none

module axi_wr_arbiter #(
	parameter int NUM_BANKS = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic [NUM_BANKS-1:0] req_i,
	input  wb_pkg::addr_t        addr_i [NUM_BANKS],
	input  wb_pkg::data_t        data_i [NUM_BANKS],
	output logic [NUM_BANKS-1:0] gnt_ready_o,

	output wb_pkg::axi_id_t      awid_o,
	output wb_pkg::addr_t        awaddr_o,
	output logic                 awvalid_o,
	input  logic                 awready_i,

	output wb_pkg::axi_id_t      wid_o,
	output wb_pkg::data_t        wdata_o,
	output logic                 wvalid_o,
	input  logic                 wready_i
);

	localparam int IDX_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

	logic [IDX_W-1:0] last_q;	// bank served most recently
	logic             locked_q;
	logic [IDX_W-1:0] lock_idx_q;
	logic [IDX_W-1:0] pick;
	logic             found;
	logic [IDX_W-1:0] sel;
	logic             valid;
	logic             handshake;

	// first pending bank after the last one served
	always_comb begin
		pick  = last_q;
		found = 1'b0;
		for (int i = 1; i <= NUM_BANKS; i++) begin
			if (!found && req_i[(int'(last_q) + i) % NUM_BANKS]) begin
				pick  = IDX_W'((int'(last_q) + i) % NUM_BANKS);
				found = 1'b1;
			end
		end
	end

	assign sel       = locked_q ? lock_idx_q : pick;
	assign valid     = locked_q || found;
	assign handshake = valid && awready_i && wready_i;

	always_comb begin
		gnt_ready_o = '0;
		gnt_ready_o[sel] = handshake;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_q     <= '0;
			locked_q   <= 1'b0;
			lock_idx_q <= '0;
		end else if (handshake) begin
			last_q   <= sel;
			locked_q <= 1'b0;
		end else if (valid) begin
			// port is stalled, keep the same bank on the bus
			locked_q   <= 1'b1;
			lock_idx_q <= sel;
		end
	end

	assign awvalid_o = valid;
	assign wvalid_o  = valid;
	assign awid_o    = wb_pkg::axi_id_t'(sel);
	assign wid_o     = wb_pkg::axi_id_t'(sel);
	assign awaddr_o  = addr_i[sel];
	assign wdata_o   = data_i[sel];

endmodule

`default_nettype wire

// File: hw/wb_subsys.sv
`default_nettype none

module wb_subsys #(
	parameter int NUM_BANKS  = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic            clk,
	input  logic            rst_n,

	input  logic            evict_i,
	input  wb_pkg::addr_t   evict_addr_i,
	input  wb_pkg::data_t   evict_data_i,
	output logic            evict_afull_o,

	output wb_pkg::axi_id_t awid_o,
	output wb_pkg::addr_t   awaddr_o,
	output logic            awvalid_o,
	input  logic            awready_i,

	output wb_pkg::axi_id_t wid_o,
	output wb_pkg::data_t   wdata_o,
	output logic            wvalid_o,
	input  logic            wready_i
);

	logic [NUM_BANKS-1:0] push;
	logic [NUM_BANKS-1:0] bank_afull;
	logic [NUM_BANKS-1:0] req;
	logic [NUM_BANKS-1:0] gnt_ready;
	wb_pkg::addr_t        q_addr [NUM_BANKS];
	wb_pkg::data_t        q_data [NUM_BANKS];

	evict_router #(
		.NUM_BANKS (NUM_BANKS)
	) u_router (
		.evict_i       (evict_i),
		.evict_addr_i  (evict_addr_i),
		.bank_afull_i  (bank_afull),
		.push_o        (push),
		.evict_afull_o (evict_afull_o)
	);

	generate
		for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
			wb_queue #(
				.FIFO_DEPTH (FIFO_DEPTH)
			) u_queue (
				.clk         (clk),
				.rst_n       (rst_n),
				.push_i      (push[k]),
				.push_addr_i (evict_addr_i),
				.push_data_i (evict_data_i),
				.afull_o     (bank_afull[k]),
				.req_o       (req[k]),
				.addr_o      (q_addr[k]),
				.data_o      (q_data[k]),
				.gnt_ready_i (gnt_ready[k])
			);
		end
	endgenerate

	axi_wr_arbiter #(
		.NUM_BANKS (NUM_BANKS)
	) u_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (req),
		.addr_i      (q_addr),
		.data_i      (q_data),
		.gnt_ready_o (gnt_ready),
		.awid_o      (awid_o),
		.awaddr_o    (awaddr_o),
		.awvalid_o   (awvalid_o),
		.awready_i   (awready_i),
		.wid_o       (wid_o),
		.wdata_o     (wdata_o),
		.wvalid_o    (wvalid_o),
		.wready_i    (wready_i)
	);

endmodule

`default_nettype wire

// File: test/wb_monitor.sv
`default_nettype none

module wb_monitor #(
	parameter int NUM_BANKS  = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            evict_i,
	input  wb_pkg::addr_t   evict_addr_i,
	input  wb_pkg::data_t   evict_data_i,
	input  logic            evict_afull_i,
	input  wb_pkg::axi_id_t awid_i,
	input  wb_pkg::addr_t   awaddr_i,
	input  logic            awvalid_i,
	input  logic            awready_i,
	input  wb_pkg::axi_id_t wid_i,
	input  wb_pkg::data_t   wdata_i,
	input  logic            wvalid_i,
	input  logic            wready_i,
	output int              errors_o,
	output int              transfers_o,
	output int              pending_o
);

	// one model queue per bank, a line counts from its strobe until its handshake
	wb_pkg::addr_t model_addr [NUM_BANKS][$];
	wb_pkg::data_t model_data [NUM_BANKS][$];
	int errors = 0;
	int transfers = 0;
	int pending = 0;

	function automatic int bank_of(input wb_pkg::addr_t addr);
		return int'((addr >> wb_pkg::OFFSET_W) % NUM_BANKS);
	endfunction

	function automatic wb_pkg::addr_t line_addr(input wb_pkg::addr_t addr);
		return addr & ~wb_pkg::addr_t'((1 << wb_pkg::OFFSET_W) - 1);
	endfunction

	function automatic int pending_lines();
		int total;
		total = 0;
		for (int k = 0; k < NUM_BANKS; k++) begin
			total += model_addr[k].size();
		end
		return total;
	endfunction

	function automatic logic model_afull();
		logic level;
		level = 1'b0;
		for (int k = 0; k < NUM_BANKS; k++) begin
			if (model_addr[k].size() >= FIFO_DEPTH - 1) level = 1'b1;
		end
		return level;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("Error: time %0t %s expected 0x%0h actual 0x%0h",
			$time, name, expected, actual);
		errors++;
	endtask

	// outputs settle between edges, so the model looks at the falling edge
	always @(negedge clk) begin : sample
		int bank;
		if (rst_n) begin
			if (evict_afull_i !== model_afull()) begin
				report_mismatch("evict_afull_o", 64'(model_afull()), 64'(evict_afull_i));
			end
			if (pending_lines() == 0 && awvalid_i !== 1'b0) begin
				report_mismatch("awvalid_o", 64'(0), 64'(awvalid_i));	// nothing to send
			end
			if (awvalid_i && awready_i && wvalid_i && wready_i) begin
				bank = int'(awid_i);
				if (wid_i !== awid_i) report_mismatch("wid_o", 64'(awid_i), 64'(wid_i));
				if (bank_of(awaddr_i) != bank) begin
					report_mismatch("awid_o", 64'(bank_of(awaddr_i)), 64'(awid_i));
				end
				if (bank >= NUM_BANKS) begin
					$display("transfer at time %0t names bank %0d, which does not exist",
						$time, bank);
					errors++;
				end else if (model_addr[bank].size() == 0) begin
					$display("transfer at time %0t from bank %0d, which holds no line",
						$time, bank);
					errors++;
				end else begin
					if (awaddr_i !== model_addr[bank][0]) begin
						report_mismatch("awaddr_o", 64'(model_addr[bank][0]), 64'(awaddr_i));
					end
					if (wdata_i !== model_data[bank][0]) begin
						report_mismatch("wdata_o", model_data[bank][0], wdata_i);
					end
					void'(model_addr[bank].pop_front());
					void'(model_data[bank].pop_front());
				end
				transfers++;
			end
			if (evict_i) begin
				model_addr[bank_of(evict_addr_i)].push_back(line_addr(evict_addr_i));
				model_data[bank_of(evict_addr_i)].push_back(evict_data_i);
			end
			pending = pending_lines();	// lines the drain still waits for
		end
	end

	assign errors_o    = errors;
	assign transfers_o = transfers;
	assign pending_o   = pending;

endmodule

`default_nettype wire

// File: test/wb_subsys_checker.sv
`default_nettype none

module wb_subsys_checker (
	input logic            clk,
	input logic            rst_n,
	input logic            evict_afull_i,
	input wb_pkg::axi_id_t awid_i,
	input wb_pkg::addr_t   awaddr_i,
	input logic            awvalid_i,
	input logic            awready_i,
	input wb_pkg::data_t   wdata_i,
	input logic            wvalid_i,
	input logic            wready_i
);

	int fail_count = 0;	// read by the testbench at the end of the run

	// AW and W are one request, so the valids never split
	a_valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid_i == wvalid_i)
	else begin
		$error("awvalid_o and wvalid_o differ");
		fail_count++;
	end

	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(awvalid_i && !(awready_i && wready_i)) |=>
		(awvalid_i && $stable(awid_i) && $stable(awaddr_i) && $stable(wdata_i)))
	else begin
		$error("request changed or dropped while the AXI port was stalled");
		fail_count++;
	end

	a_afull_reset: assert property (@(posedge clk) !rst_n |=> !evict_afull_i)
	else begin
		$error("evict_afull_o high in the cycle after reset");
		fail_count++;
	end

endmodule

bind wb_subsys wb_subsys_checker u_checker (
	.clk           (clk),
	.rst_n         (rst_n),
	.evict_afull_i (evict_afull_o),
	.awid_i        (awid_o),
	.awaddr_i      (awaddr_o),
	.awvalid_i     (awvalid_o),
	.awready_i     (awready_i),
	.wdata_i       (wdata_o),
	.wvalid_i      (wvalid_o),
	.wready_i      (wready_i)
);

`default_nettype wire

// File: test/wb_subsys_tb.sv
`default_nettype none

module wb_subsys_tb;

	localparam int NUM_BANKS  = 4;
	localparam int FIFO_DEPTH = 4;

	localparam int READY_LOW    = 0;
	localparam int READY_RANDOM = 1;
	localparam int READY_HIGH   = 2;

	logic            clk;
	logic            rst_n;
	logic            evict_i;
	wb_pkg::addr_t   evict_addr_i;
	wb_pkg::data_t   evict_data_i;
	logic            evict_afull_o;
	wb_pkg::axi_id_t awid_o;
	wb_pkg::addr_t   awaddr_o;
	logic            awvalid_o;
	logic            awready_i;
	wb_pkg::axi_id_t wid_o;
	wb_pkg::data_t   wdata_o;
	logic            wvalid_o;
	logic            wready_i;

	integer seed = 32'h7979e694;
	int strobes = 0;
	int tb_errors = 0;
	int model_errors;
	int transfers;
	int pending;

	wb_subsys #(
		.NUM_BANKS  (NUM_BANKS),
		.FIFO_DEPTH (FIFO_DEPTH)
	) uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.evict_i       (evict_i),
		.evict_addr_i  (evict_addr_i),
		.evict_data_i  (evict_data_i),
		.evict_afull_o (evict_afull_o),
		.awid_o        (awid_o),
		.awaddr_o      (awaddr_o),
		.awvalid_o     (awvalid_o),
		.awready_i     (awready_i),
		.wid_o         (wid_o),
		.wdata_o       (wdata_o),
		.wvalid_o      (wvalid_o),
		.wready_i      (wready_i)
	);

	wb_monitor #(
		.NUM_BANKS  (NUM_BANKS),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_monitor (
		.clk           (clk),
		.rst_n         (rst_n),
		.evict_i       (evict_i),
		.evict_addr_i  (evict_addr_i),
		.evict_data_i  (evict_data_i),
		.evict_afull_i (evict_afull_o),
		.awid_i        (awid_o),
		.awaddr_i      (awaddr_o),
		.awvalid_i     (awvalid_o),
		.awready_i     (awready_i),
		.wid_i         (wid_o),
		.wdata_i       (wdata_o),
		.wvalid_i      (wvalid_o),
		.wready_i      (wready_i),
		.errors_o      (model_errors),
		.transfers_o   (transfers),
		.pending_o     (pending)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// one cycle of stimulus, driven just after the rising edge
	task automatic drive_cycle(input bit allow_strobe, input int ready_mode);
		@(posedge clk);
		#1;
		if (allow_strobe && !evict_afull_o && (($random(seed) & 1) != 0)) begin
			evict_i      = 1'b1;
			evict_addr_i = $random(seed);	// offset bits stay random on purpose
			evict_data_i = {$random(seed), $random(seed)};
			strobes++;
		end else begin
			evict_i = 1'b0;
		end
		case (ready_mode)
			READY_LOW: begin
				awready_i = 1'b0;
				wready_i  = 1'b0;
			end
			READY_HIGH: begin
				awready_i = 1'b1;
				wready_i  = 1'b1;
			end
			default: begin
				awready_i = (($random(seed) & 3) != 0);
				wready_i  = (($random(seed) & 3) != 0);
			end
		endcase
	endtask

	task automatic run_cycles(input int count, input bit allow_strobe, input int ready_mode);
		for (int n = 0; n < count; n++) begin
			drive_cycle(allow_strobe, ready_mode);
		end
	endtask

	task automatic fill_until_afull(input int limit);
		int n;
		n = 0;
		while (evict_afull_o !== 1'b1 && n < limit) begin
			drive_cycle(1'b1, READY_LOW);
			n++;
		end
		if (evict_afull_o !== 1'b1) begin
			$display("timeout at %0t: evict_afull_o never rose while the port was stalled",
				$time);
			tb_errors++;
		end
	endtask

	task automatic drain(input int ready_mode, input int limit);
		int n;
		n = 0;
		while ((pending != 0 || awvalid_o !== 1'b0) && n < limit) begin
			drive_cycle(1'b0, ready_mode);
			n++;
		end
		if (pending != 0 || awvalid_o !== 1'b0) begin
			$display("timeout at %0t: %0d lines still pending after the drain", $time, pending);
			tb_errors++;
		end
	endtask

	initial begin : main
		int assert_errors;
		int total;
		rst_n        = 1'b0;
		evict_i      = 1'b0;
		evict_addr_i = '0;
		evict_data_i = '0;
		awready_i    = 1'b0;
		wready_i     = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		run_cycles(5, 1'b0, READY_HIGH);	// idle port right after reset
		run_cycles(600, 1'b1, READY_RANDOM);
		fill_until_afull(200);
		run_cycles(20, 1'b1, READY_LOW);
		drain(READY_RANDOM, 500);
		run_cycles(300, 1'b1, READY_RANDOM);
		fill_until_afull(200);
		run_cycles(10, 1'b1, READY_LOW);
		drain(READY_HIGH, 200);

		assert_errors = uut.u_checker.fail_count;
		if (strobes != transfers) begin
			$display("Error: time %0t transfer count expected %0d actual %0d",
				$time, strobes, transfers);
			tb_errors++;
		end
		total = model_errors + assert_errors + tb_errors;
		$display("error counts: model %0d, assertions %0d, testbench %0d (%0d lines sent)",
			model_errors, assert_errors, tb_errors, transfers);
		if (total == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: wb_subsys.f
hw/wb_pkg.sv
hw/wb_fifo.sv
hw/wb_queue.sv
hw/evict_router.sv
hw/axi_wr_arbiter.sv
hw/wb_subsys.sv
test/wb_monitor.sv
test/wb_subsys_checker.sv
test/wb_subsys_tb.sv

// File: run.sh
#!/bin/sh
# compile the write-back subsystem with its testbench and run it with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module wb_subsys_tb \
	-f wb_subsys.f \
	&& ./obj_dir/Vwb_subsys_tb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^ALL CHECKS PASSED$" sim.log 2>/dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
